// File: build.f
+incdir+tests
design/bp_pkg.sv
design/bp_sample_store.sv
design/bp_delta_engine.sv
design/bp_delta_store.sv
design/bp_gradient_engine.sv
design/bp_top.sv
tests/tb_bp.sv

// File: run.sh
#!/bin/sh
# Builds the backprop testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f build.f \
	--top-module tb_bp -o tb_bp > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_bp > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

// File: tests/bp_model.svh
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

// Current sample and the weight memory behind the request port
logic [15:0] in_v  [bp_pkg::N_IN];
logic [15:0] hid_v [bp_pkg::N_HID];
logic [15:0] out_v [bp_pkg::N_OUT];
logic [15:0] exp_v [bp_pkg::N_OUT];
logic [15:0] wmem  [16];
logic [15:0] d_out [bp_pkg::N_OUT];
logic [15:0] d_hid [bp_pkg::N_HID];

logic [20:0] grad_q[$];     // {layer, addr, data}
logic [3:0]  wreq_q[$];
logic [15:0] rsp_data_q[$];
int          rsp_due_q[$];  // Cycle from which a response may go out

// Q4.12 product, floor toward minus infinity
function automatic logic [15:0] q_mul(input logic [15:0] a, input logic [15:0] b);
	int prod;
	prod = int'($signed(a)) * int'($signed(b));
	return 16'(prod >>> bp_pkg::FRAC_W);
endfunction

function automatic logic [15:0] leak_if_neg(input logic [15:0] v, input logic neg);
	if (neg)
		return 16'(int'($signed(v)) >>> bp_pkg::LEAKY_SHIFT); // Slope 1/8
	return v;
endfunction

function automatic logic [15:0] lr_scale(input logic [15:0] v);
	return 16'(int'($signed(v)) >>> bp_pkg::LR_SHIFT);
endfunction

function automatic logic [1:0] group_last(input int sel);
	case (sel)
		bp_pkg::SEL_IN:  return 2'(bp_pkg::N_IN - 1);
		bp_pkg::SEL_HID: return 2'(bp_pkg::N_HID - 1);
		default:         return 2'(bp_pkg::N_OUT - 1);
	endcase
endfunction

function automatic logic [15:0] sample_word(input int sel, input int a);
	case (sel)
		bp_pkg::SEL_IN:  return in_v[a];
		bp_pkg::SEL_HID: return hid_v[a];
		bp_pkg::SEL_OUT: return out_v[a];
		default:         return exp_v[a];
	endcase
endfunction

// Deltas, weight request order and gradient stream of one sample
task automatic build_expected();
	logic [15:0] sum;
	logic [15:0] pt;
	for (int k = 0; k < bp_pkg::N_OUT; k++)
		d_out[k] = leak_if_neg(out_v[k] - exp_v[k], out_v[k][15]);
	for (int j = 0; j < bp_pkg::N_HID; j++) begin
		sum = '0;
		for (int k = 0; k < bp_pkg::N_OUT; k++) begin
			wreq_q.push_back(4'(k * (bp_pkg::N_HID + 1) + j));
			sum = sum + q_mul(d_out[k], wmem[k * (bp_pkg::N_HID + 1) + j]);
		end
		d_hid[j] = leak_if_neg(sum, hid_v[j][15]);
	end
	for (int k = 0; k < bp_pkg::N_OUT; k++)
		for (int p = 0; p <= bp_pkg::N_HID; p++) begin
			pt = (p < bp_pkg::N_HID) ? hid_v[p] : bp_pkg::ONE; // Bias point last
			grad_q.push_back({bp_pkg::GL_OUT, 4'(k * (bp_pkg::N_HID + 1) + p),
				lr_scale(q_mul(d_out[k], pt))});
		end
	for (int j = 0; j < bp_pkg::N_HID; j++)
		for (int p = 0; p <= bp_pkg::N_IN; p++) begin
			pt = (p < bp_pkg::N_IN) ? in_v[p] : bp_pkg::ONE;
			grad_q.push_back({bp_pkg::GL_HID, 4'(j * (bp_pkg::N_IN + 1) + p),
				lr_scale(q_mul(d_hid[j], pt))});
		end
endtask

// Latency of 1 to 4 cycles, responses kept in request order
task automatic queue_response(input logic [3:0] addr);
	rsp_data_q.push_back(wmem[addr]);
	rsp_due_q.push_back(cyc + 1 + int'(next_rand() % 4));
endtask

task automatic drive_response();
	if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
		i_wrsp_valid = 1'b1;
		i_wrsp_data  = rsp_data_q.pop_front();
		void'(rsp_due_q.pop_front());
	end else begin
		i_wrsp_valid = 1'b0;
		i_wrsp_data  = 16'(next_rand()); // Noise on idle data
	end
endtask

`endif

// File: tests/tb_bp.sv
`timescale 1ns/1ps
module tb_bp;
	localparam int N_SAMPLES  = 20;
	localparam int PERIOD     = 8;
	localparam int RUN_CYCLES = 400; // Budget per sample

	logic                       clk;
	logic                       rst_n;
	logic                       i_load_valid;
	logic [bp_pkg::SEL_W-1:0]   i_load_sel;
	logic [bp_pkg::ADDR_W-1:0]  i_load_addr;
	logic [bp_pkg::DATA_W-1:0]  i_load_data;
	logic                       o_load_ready;
	logic                       o_wreq_valid;
	logic [bp_pkg::WADDR_W-1:0] o_wreq_addr;
	logic                       i_wreq_ready;
	logic                       i_wrsp_valid;
	logic [bp_pkg::DATA_W-1:0]  i_wrsp_data;
	logic                       o_grad_valid;
	logic                       o_grad_layer;
	logic [bp_pkg::GADDR_W-1:0] o_grad_addr;
	logic [bp_pkg::DATA_W-1:0]  o_grad_data;
	logic                       i_grad_ready;

	logic [31:0] rng = 32'hcba9;
	int          cyc;
	logic        ld_valid;
	logic [1:0]  ld_sel;
	logic [1:0]  ld_addr;
	logic [15:0] ld_data;
	logic        load_acc;
	logic        in_run;   // Load port must stay closed
	logic        idle_chk; // Incomplete sample, nothing may start
	logic        held;     // Gradient stalled at the last edge
	logic [20:0] held_grad;

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	`include "bp_model.svh"

	bp_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
			abort_run();
		end
	endtask

	function automatic logic [15:0] rand_q();
		logic [31:0] r;
		r = next_rand();
		return {{2{r[13]}}, r[13:0]}; // Within +-2.0
	endfunction

	task automatic drive_inputs();
		logic [31:0] r;
		cyc++;
		r = next_rand();
		i_grad_ready = (r[1:0] != 2'd0);
		i_wreq_ready = (r[3:2] != 2'd0);
		i_load_valid = ld_valid;
		i_load_sel   = ld_sel;
		i_load_addr  = ld_addr;
		i_load_data  = ld_data;
		drive_response();
	endtask

	// Mid-cycle view of the handshakes that fire at the next edge
	task automatic observe_ports();
		logic [20:0] g;
		logic [20:0] e;
		load_acc = i_load_valid && o_load_ready;
		if (in_run)
			check_value("o_load_ready", o_load_ready, 0);
		if (idle_chk) begin
			check_value("o_wreq_valid", o_wreq_valid, 0);
			check_value("o_grad_valid", o_grad_valid, 0);
			check_value("o_load_ready", o_load_ready, 1);
		end
		if (o_wreq_valid && i_wreq_ready) begin
			if (wreq_q.size() == 0) begin
				$display("Weight request to %h at %0t ns with none expected", o_wreq_addr, $time);
				abort_run();
			end else begin
				check_value("o_wreq_addr", o_wreq_addr, wreq_q.pop_front());
				queue_response(o_wreq_addr);
			end
		end
		g = {o_grad_layer, o_grad_addr, o_grad_data};
		if (held) begin
			check_value("o_grad_valid", o_grad_valid, 1); // Stalled gradient lost
			check_value("stalled gradient", g, held_grad);
		end
		if (o_grad_valid && i_grad_ready) begin
			if (grad_q.size() == 0) begin
				$display("Extra gradient at %0t ns, addr %h", $time, o_grad_addr);
				abort_run();
			end else begin
				e = grad_q.pop_front();
				check_value("o_grad_layer", o_grad_layer, e[20]);
				check_value("o_grad_addr", o_grad_addr, e[19:16]);
				check_value("o_grad_data", o_grad_data, e[15:0]);
				if (grad_q.size() == 0)
					in_run = 1'b0;
			end
		end
		held      = o_grad_valid && !i_grad_ready;
		held_grad = g;
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
		drive_inputs();
		@(negedge clk);
		observe_ports();
	endtask

	task automatic load_word(input int sel, input int addr);
		ld_valid = 1'b1;
		ld_sel   = 2'(sel);
		ld_addr  = 2'(addr);
		ld_data  = sample_word(sel, addr);
		do
			tick();
		while (!load_acc);
		ld_valid = 1'b0;
	endtask

	task automatic run_sample(input int s);
		int skip_sel;
		for (int i = 0; i < bp_pkg::N_IN; i++)
			in_v[i] = rand_q();
		for (int j = 0; j < bp_pkg::N_HID; j++)
			hid_v[j] = rand_q();
		for (int k = 0; k < bp_pkg::N_OUT; k++) begin
			out_v[k] = rand_q();
			exp_v[k] = rand_q();
		end
		for (int a = 0; a < 16; a++)
			wmem[a] = rand_q();
		build_expected();
		skip_sel = s % 4; // This group's last word comes late
		for (int sel = 0; sel < 4; sel++)
			for (int a = 0; a <= group_last(sel); a++)
				if (!(sel == skip_sel && a == group_last(sel)))
					load_word(sel, a);
		idle_chk = 1'b1;
		repeat (6) tick();
		idle_chk = 1'b0;
		load_word(skip_sel, group_last(skip_sel));
		in_run = 1'b1;
		while (grad_q.size() > 0)
			tick();
		tick();
		check_value("o_load_ready", o_load_ready, 1);
		check_value("weight requests missing", wreq_q.size(), 0);
		check_value("weight responses unused", rsp_due_q.size(), 0);
	endtask

	initial begin
		#(N_SAMPLES * RUN_CYCLES * PERIOD);
		$display("Timeout after %0d cycles without finishing", N_SAMPLES * RUN_CYCLES);
		abort_run();
	end

	initial begin
		rst_n        = 1'b0;
		i_load_valid = 1'b0;
		i_load_sel   = '0;
		i_load_addr  = '0;
		i_load_data  = '0;
		i_wreq_ready = 1'b0;
		i_wrsp_valid = 1'b0;
		i_wrsp_data  = '0;
		i_grad_ready = 1'b0;
		ld_valid     = 1'b0;
		ld_sel       = '0;
		ld_addr      = '0;
		ld_data      = '0;
		in_run       = 1'b0;
		idle_chk     = 1'b0;
		held         = 1'b0;
		cyc          = 0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		check_value("o_load_ready", o_load_ready, 1);
		check_value("o_wreq_valid", o_wreq_valid, 0);
		check_value("o_grad_valid", o_grad_valid, 0);
		for (int s = 0; s < N_SAMPLES; s++)
			run_sample(s);
		$display("Regression passed");
		$finish;
	end
endmodule

// File: design/bp_top.sv
`timescale 1ns/1ps
module bp_top (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_load_valid,
	input  logic [bp_pkg::SEL_W-1:0]      i_load_sel,
	input  logic [bp_pkg::ADDR_W-1:0]     i_load_addr,
	input  logic [bp_pkg::DATA_W-1:0]     i_load_data,
	output logic                          o_load_ready,
	output logic                          o_wreq_valid,
	output logic [bp_pkg::WADDR_W-1:0]    o_wreq_addr,
	input  logic                          i_wreq_ready,
	input  logic                          i_wrsp_valid,
	input  logic [bp_pkg::DATA_W-1:0]     i_wrsp_data,
	output logic                          o_grad_valid,
	output logic                          o_grad_layer,
	output logic [bp_pkg::GADDR_W-1:0]    o_grad_addr,
	output logic [bp_pkg::DATA_W-1:0]     o_grad_data,
	input  logic                          i_grad_ready
);
	logic                      start;
	logic                      run_done;
	logic [bp_pkg::SEL_W-1:0]  pt_sel;
	logic [bp_pkg::ADDR_W-1:0] pt_addr;
	logic [bp_pkg::DATA_W-1:0] pt_data;
	logic [bp_pkg::ADDR_W-1:0] out_idx;
	logic [bp_pkg::DATA_W-1:0] out_act;
	logic [bp_pkg::DATA_W-1:0] exp_val;
	logic [bp_pkg::N_OUT-1:0]  out_sign;
	logic [bp_pkg::N_HID-1:0]  hid_sign;
	logic                      wr_en;
	logic                      wr_layer;
	logic [bp_pkg::ADDR_W-1:0] wr_idx;
	logic [bp_pkg::DATA_W-1:0] wr_data;
	logic [bp_pkg::ADDR_W-1:0] prod_rd_idx;
	logic [bp_pkg::DATA_W-1:0] prod_rd_data;
	logic                      cons_rd_layer;
	logic [bp_pkg::ADDR_W-1:0] cons_rd_idx;
	logic [bp_pkg::DATA_W-1:0] cons_rd_data;
	logic                      out_full;
	logic                      hid_full;

	bp_sample_store u_sample (
		.clk(clk), .rst_n(rst_n),
		.i_load_valid(i_load_valid), .i_load_sel(i_load_sel),
		.i_load_addr(i_load_addr), .i_load_data(i_load_data),
		.o_load_ready(o_load_ready), .o_start(start), .i_run_done(run_done),
		.i_rd_sel(pt_sel), .i_rd_addr(pt_addr), .o_rd_data(pt_data),
		.i_out_idx(out_idx), .o_out_act(out_act), .o_exp(exp_val),
		.o_out_sign(out_sign), .o_hid_sign(hid_sign)
	);

	bp_delta_engine u_delta (
		.clk(clk), .rst_n(rst_n), .i_start(start),
		.o_out_idx(out_idx), .i_out_act(out_act), .i_exp(exp_val),
		.i_out_sign(out_sign), .i_hid_sign(hid_sign),
		.o_wreq_valid(o_wreq_valid), .o_wreq_addr(o_wreq_addr), .i_wreq_ready(i_wreq_ready),
		.i_wrsp_valid(i_wrsp_valid), .i_wrsp_data(i_wrsp_data),
		.o_wr_en(wr_en), .o_wr_layer(wr_layer), .o_wr_idx(wr_idx), .o_wr_data(wr_data),
		.o_rd_idx(prod_rd_idx), .i_out_delta(prod_rd_data)
	);

	bp_delta_store u_dstore (
		.clk(clk), .rst_n(rst_n), .i_start(start),
		.i_wr_en(wr_en), .i_wr_layer(wr_layer), .i_wr_idx(wr_idx), .i_wr_data(wr_data),
		.i_prod_rd_idx(prod_rd_idx), .o_prod_rd_data(prod_rd_data),
		.i_cons_rd_layer(cons_rd_layer), .i_cons_rd_idx(cons_rd_idx),
		.o_cons_rd_data(cons_rd_data), .o_out_full(out_full), .o_hid_full(hid_full)
	);

	bp_gradient_engine u_grad (
		.clk(clk), .rst_n(rst_n), .i_start(start),
		.i_out_full(out_full), .i_hid_full(hid_full),
		.o_rd_layer(cons_rd_layer), .o_rd_idx(cons_rd_idx), .i_delta(cons_rd_data),
		.o_pt_sel(pt_sel), .o_pt_addr(pt_addr), .i_point(pt_data),
		.o_grad_valid(o_grad_valid), .o_grad_layer(o_grad_layer),
		.o_grad_addr(o_grad_addr), .o_grad_data(o_grad_data),
		.i_grad_ready(i_grad_ready), .o_run_done(run_done)
	);
endmodule

// File: design/bp_gradient_engine.sv
`timescale 1ns/1ps
module bp_gradient_engine (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_start,
	input  logic                          i_out_full,
	input  logic                          i_hid_full,
	output logic                          o_rd_layer,
	output logic [bp_pkg::ADDR_W-1:0]     o_rd_idx,
	input  logic [bp_pkg::DATA_W-1:0]     i_delta,
	output logic [bp_pkg::SEL_W-1:0]      o_pt_sel,
	output logic [bp_pkg::ADDR_W-1:0]     o_pt_addr,
	input  logic [bp_pkg::DATA_W-1:0]     i_point,
	output logic                          o_grad_valid,
	output logic                          o_grad_layer,
	output logic [bp_pkg::GADDR_W-1:0]    o_grad_addr,
	output logic [bp_pkg::DATA_W-1:0]     o_grad_data,
	input  logic                          i_grad_ready,
	output logic                          o_run_done
);
	logic                       issuing;
	logic                       layer;
	logic                       bias;    // Current point is the ONE input
	logic [bp_pkg::ADDR_W-1:0]  d_idx;
	logic [bp_pkg::ADDR_W-1:0]  p_idx;
	logic [bp_pkg::GADDR_W-1:0] g_addr;
	logic [bp_pkg::ADDR_W-1:0]  d_last;
	logic [bp_pkg::ADDR_W-1:0]  pt_last;
	logic [bp_pkg::DATA_W-1:0]  point;
	logic                       deltas_ok;
	logic                       fire;
	logic                       run_last;
	logic                       grad_last;

	assign d_last  = (layer == bp_pkg::GL_OUT) ? bp_pkg::OUT_LAST : bp_pkg::HID_LAST;
	assign pt_last = (layer == bp_pkg::GL_OUT) ? bp_pkg::HID_LAST : bp_pkg::IN_LAST;

	assign o_rd_layer = layer;
	assign o_rd_idx   = d_idx;
	assign o_pt_sel   = (layer == bp_pkg::GL_OUT) ? bp_pkg::SEL_HID : bp_pkg::SEL_IN;
	assign o_pt_addr  = p_idx;
	assign point      = bias ? bp_pkg::ONE : i_point;

	assign deltas_ok = (layer == bp_pkg::GL_OUT) ? i_out_full : i_hid_full;
	assign fire      = issuing & deltas_ok & (~o_grad_valid | i_grad_ready);
	assign run_last  = bias & (d_idx == d_last) & (layer == bp_pkg::GL_HID);
	assign o_run_done = o_grad_valid & i_grad_ready & grad_last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issuing <= 1'b0;
			layer   <= bp_pkg::GL_OUT;
			bias    <= 1'b0;
			d_idx   <= '0;
			p_idx   <= '0;
			g_addr  <= '0;
		end else if (i_start) begin
			issuing <= 1'b1;
			layer   <= bp_pkg::GL_OUT;
			bias    <= 1'b0;
			d_idx   <= '0;
			p_idx   <= '0;
			g_addr  <= '0;
		end else if (fire) begin
			if (bias) begin
				bias  <= 1'b0;
				p_idx <= '0;
				if (d_idx == d_last) begin
					d_idx  <= '0;
					g_addr <= '0;
					if (layer == bp_pkg::GL_OUT)
						layer <= bp_pkg::GL_HID;
					else
						issuing <= 1'b0;
				end else begin
					d_idx  <= d_idx + 1'b1;
					g_addr <= g_addr + 1'b1;
				end
			end else begin
				if (p_idx == pt_last)
					bias <= 1'b1;
				else
					p_idx <= p_idx + 1'b1;
				g_addr <= g_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_grad_valid <= 1'b0;
		else if (fire)
			o_grad_valid <= 1'b1;
		else if (i_grad_ready)
			o_grad_valid <= 1'b0;
	end

	// Held while the sink stalls
	always_ff @(posedge clk) begin
		if (fire) begin
			o_grad_layer <= layer;
			o_grad_addr  <= g_addr;
			o_grad_data  <= bp_pkg::fx_lr(bp_pkg::fx_mul(i_delta, point));
			grad_last    <= run_last;
		end
	end
endmodule

// File: design/bp_delta_store.sv
`timescale 1ns/1ps
module bp_delta_store (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_start,
	input  logic                          i_wr_en,
	input  logic                          i_wr_layer,
	input  logic [bp_pkg::ADDR_W-1:0]     i_wr_idx,
	input  logic [bp_pkg::DATA_W-1:0]     i_wr_data,
	input  logic [bp_pkg::ADDR_W-1:0]     i_prod_rd_idx,
	output logic [bp_pkg::DATA_W-1:0]     o_prod_rd_data,
	input  logic                          i_cons_rd_layer,
	input  logic [bp_pkg::ADDR_W-1:0]     i_cons_rd_idx,
	output logic [bp_pkg::DATA_W-1:0]     o_cons_rd_data,
	output logic                          o_out_full,
	output logic                          o_hid_full
);
	logic [bp_pkg::DATA_W-1:0] out_delta [bp_pkg::N_OUT];
	logic [bp_pkg::DATA_W-1:0] hid_delta [bp_pkg::N_HID];
	logic [bp_pkg::ADDR_W-1:0] out_cnt;
	logic [bp_pkg::ADDR_W-1:0] hid_cnt;

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			if (i_wr_layer == bp_pkg::GL_OUT)
				out_delta[i_wr_idx] <= i_wr_data;
			else
				hid_delta[i_wr_idx] <= i_wr_data;
		end
	end

	// Flags rise on the last write of each layer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_cnt    <= '0;
			hid_cnt    <= '0;
			o_out_full <= 1'b0;
			o_hid_full <= 1'b0;
		end else if (i_start) begin
			out_cnt    <= '0;
			hid_cnt    <= '0;
			o_out_full <= 1'b0;
			o_hid_full <= 1'b0;
		end else if (i_wr_en) begin
			if (i_wr_layer == bp_pkg::GL_OUT) begin
				out_cnt <= out_cnt + 1'b1;
				if (out_cnt == bp_pkg::OUT_LAST)
					o_out_full <= 1'b1;
			end else begin
				hid_cnt <= hid_cnt + 1'b1;
				if (hid_cnt == bp_pkg::HID_LAST)
					o_hid_full <= 1'b1;
			end
		end
	end

	assign o_prod_rd_data = out_delta[i_prod_rd_idx];
	assign o_cons_rd_data = (i_cons_rd_layer == bp_pkg::GL_OUT) ? out_delta[i_cons_rd_idx] :
		hid_delta[i_cons_rd_idx];
endmodule

// File: design/bp_delta_engine.sv
`timescale 1ns/1ps
module bp_delta_engine (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_start,
	output logic [bp_pkg::ADDR_W-1:0]     o_out_idx,
	input  logic [bp_pkg::DATA_W-1:0]     i_out_act,
	input  logic [bp_pkg::DATA_W-1:0]     i_exp,
	input  logic [bp_pkg::N_OUT-1:0]      i_out_sign,
	input  logic [bp_pkg::N_HID-1:0]      i_hid_sign,
	output logic                          o_wreq_valid,
	output logic [bp_pkg::WADDR_W-1:0]    o_wreq_addr,
	input  logic                          i_wreq_ready,
	input  logic                          i_wrsp_valid,
	input  logic [bp_pkg::DATA_W-1:0]     i_wrsp_data,
	output logic                          o_wr_en,
	output logic                          o_wr_layer,
	output logic [bp_pkg::ADDR_W-1:0]     o_wr_idx,
	output logic [bp_pkg::DATA_W-1:0]     o_wr_data,
	output logic [bp_pkg::ADDR_W-1:0]     o_rd_idx,
	input  logic [bp_pkg::DATA_W-1:0]     i_out_delta
);
	logic                      run_out;  // Output delta phase
	logic                      run_hid;  // Weight fetch phase
	logic [bp_pkg::ADDR_W-1:0] k_cnt;    // Output node, also response index
	logic [bp_pkg::ADDR_W-1:0] rsp_j;
	logic [bp_pkg::ADDR_W-1:0] req_j;
	logic [bp_pkg::ADDR_W-1:0] req_k;
	logic                      req_done;
	logic [bp_pkg::ADDR_W-1:0] pend;     // Requests awaiting response
	logic                      req_fire;
	logic                      rsp_fire;
	logic [bp_pkg::DATA_W-1:0] acc;
	logic [bp_pkg::DATA_W-1:0] hid_sum;
	logic [bp_pkg::DATA_W-1:0] out_delta;
	logic [bp_pkg::DATA_W-1:0] hid_delta;

	assign o_wreq_valid = run_hid & ~req_done & (pend <= bp_pkg::OUT_LAST);
	assign o_wreq_addr  = bp_pkg::WADDR_W'(req_k * (bp_pkg::N_HID + 1) + req_j);
	assign req_fire     = o_wreq_valid & i_wreq_ready;
	assign rsp_fire     = run_hid & i_wrsp_valid;

	assign o_out_idx = k_cnt;
	assign o_rd_idx  = k_cnt;

	assign out_delta = bp_pkg::fx_leaky_deriv(i_out_act - i_exp, i_out_sign[k_cnt]);
	assign hid_sum   = acc + bp_pkg::fx_mul(i_out_delta, i_wrsp_data);
	assign hid_delta = bp_pkg::fx_leaky_deriv(hid_sum, i_hid_sign[rsp_j]);

	// One output delta per cycle, then a hidden delta per finished node
	assign o_wr_en    = run_out | (rsp_fire & (k_cnt == bp_pkg::OUT_LAST));
	assign o_wr_layer = run_out ? bp_pkg::GL_OUT : bp_pkg::GL_HID;
	assign o_wr_idx   = run_out ? k_cnt : rsp_j;
	assign o_wr_data  = run_out ? out_delta : hid_delta;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_out  <= 1'b0;
			run_hid  <= 1'b0;
			k_cnt    <= '0;
			rsp_j    <= '0;
			req_j    <= '0;
			req_k    <= '0;
			req_done <= 1'b0;
		end else begin
			if (i_start) begin
				run_out  <= 1'b1;
				k_cnt    <= '0;
				rsp_j    <= '0;
				req_j    <= '0;
				req_k    <= '0;
				req_done <= 1'b0;
			end else if (run_out) begin
				if (k_cnt == bp_pkg::OUT_LAST) begin
					run_out <= 1'b0;
					run_hid <= 1'b1;
					k_cnt   <= '0;
				end else begin
					k_cnt <= k_cnt + 1'b1;
				end
			end else if (rsp_fire) begin
				if (k_cnt == bp_pkg::OUT_LAST) begin
					k_cnt <= '0;
					rsp_j <= rsp_j + 1'b1;
					if (rsp_j == bp_pkg::HID_LAST)
						run_hid <= 1'b0; // Last hidden delta written
				end else begin
					k_cnt <= k_cnt + 1'b1;
				end
			end

			if (req_fire) begin
				if (req_k == bp_pkg::OUT_LAST) begin
					req_k <= '0;
					req_j <= req_j + 1'b1;
					if (req_j == bp_pkg::HID_LAST)
						req_done <= 1'b1;
				end else begin
					req_k <= req_k + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend <= '0;
		end else begin
			case ({req_fire, rsp_fire})
				2'b10:   pend <= pend + 1'b1;
				2'b01:   pend <= pend - 1'b1;
				default: pend <= pend;
			endcase
		end
	end

	// Running sum over k for hidden node rsp_j
	always_ff @(posedge clk) begin
		if (i_start)
			acc <= '0;
		else if (rsp_fire)
			acc <= (k_cnt == bp_pkg::OUT_LAST) ? '0 : hid_sum;
	end
endmodule

// File: design/bp_sample_store.sv
`timescale 1ns/1ps
module bp_sample_store (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          i_load_valid,
	input  logic [bp_pkg::SEL_W-1:0]      i_load_sel,
	input  logic [bp_pkg::ADDR_W-1:0]     i_load_addr,
	input  logic [bp_pkg::DATA_W-1:0]     i_load_data,
	output logic                          o_load_ready,
	output logic                          o_start,
	input  logic                          i_run_done,
	input  logic [bp_pkg::SEL_W-1:0]      i_rd_sel,
	input  logic [bp_pkg::ADDR_W-1:0]     i_rd_addr,
	output logic [bp_pkg::DATA_W-1:0]     o_rd_data,
	input  logic [bp_pkg::ADDR_W-1:0]     i_out_idx,
	output logic [bp_pkg::DATA_W-1:0]     o_out_act,
	output logic [bp_pkg::DATA_W-1:0]     o_exp,
	output logic [bp_pkg::N_OUT-1:0]      o_out_sign,
	output logic [bp_pkg::N_HID-1:0]      o_hid_sign
);
	logic [bp_pkg::DATA_W-1:0] in_act  [bp_pkg::N_IN];
	logic [bp_pkg::DATA_W-1:0] hid_act [bp_pkg::N_HID];
	logic [bp_pkg::DATA_W-1:0] out_act [bp_pkg::N_OUT];
	logic [bp_pkg::DATA_W-1:0] exp_val [bp_pkg::N_OUT];
	logic [3:0]                grp_done; // One flag per load group
	logic                      busy;
	logic                      all_done;
	logic                      load_fire;
	logic [bp_pkg::ADDR_W-1:0] last_addr;

	assign all_done     = &grp_done;
	assign o_start      = all_done;
	assign o_load_ready = ~busy & ~all_done; // Closed from run start
	assign load_fire    = i_load_valid & o_load_ready;

	always_comb begin
		case (i_load_sel)
			bp_pkg::SEL_IN:  last_addr = bp_pkg::IN_LAST;
			bp_pkg::SEL_HID: last_addr = bp_pkg::HID_LAST;
			default:         last_addr = bp_pkg::OUT_LAST; // Output and expected
		endcase
	end

	always_ff @(posedge clk) begin
		if (load_fire && i_load_addr <= last_addr) begin
			case (i_load_sel)
				bp_pkg::SEL_IN:  in_act[i_load_addr[$clog2(bp_pkg::N_IN)-1:0]] <= i_load_data;
				bp_pkg::SEL_HID: hid_act[i_load_addr] <= i_load_data;
				bp_pkg::SEL_OUT: out_act[i_load_addr] <= i_load_data;
				default:         exp_val[i_load_addr] <= i_load_data;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grp_done <= '0;
			busy     <= 1'b0;
		end else begin
			if (all_done) begin
				grp_done <= '0;
				busy     <= 1'b1;
			end else if (load_fire && i_load_addr == last_addr) begin
				grp_done[i_load_sel] <= 1'b1;
			end
			if (i_run_done)
				busy <= 1'b0;
		end
	end

	// Gradient engine reads hidden or input points here
	assign o_rd_data = (i_rd_sel == bp_pkg::SEL_HID) ? hid_act[i_rd_addr] :
		in_act[i_rd_addr[$clog2(bp_pkg::N_IN)-1:0]];

	assign o_out_act = out_act[i_out_idx];
	assign o_exp     = exp_val[i_out_idx];

	always_comb begin
		for (int k = 0; k < bp_pkg::N_OUT; k++)
			o_out_sign[k] = out_act[k][bp_pkg::DATA_W-1];
		for (int j = 0; j < bp_pkg::N_HID; j++)
			o_hid_sign[j] = hid_act[j][bp_pkg::DATA_W-1];
	end
endmodule

// File: design/bp_pkg.sv
package bp_pkg;
	localparam int N_IN    = 2;
	localparam int N_HID   = 4;
	localparam int N_OUT   = 3;
	localparam int DATA_W  = 16;
	localparam int FRAC_W  = 12; // Q4.12
	localparam int SEL_W   = 2;
	localparam int ADDR_W  = 2;
	localparam int WADDR_W = 4;
	localparam int GADDR_W = 4;

	localparam logic [DATA_W-1:0] ONE = 16'h1000; // Bias data point
	localparam int LEAKY_SHIFT = 3; // Slope 1/8
	localparam int LR_SHIFT    = 6;

	localparam logic [SEL_W-1:0] SEL_IN  = 2'd0;
	localparam logic [SEL_W-1:0] SEL_HID = 2'd1;
	localparam logic [SEL_W-1:0] SEL_OUT = 2'd2;
	localparam logic [SEL_W-1:0] SEL_EXP = 2'd3;

	localparam logic GL_OUT = 1'b1;
	localparam logic GL_HID = 1'b0;

	// Last node index per layer
	localparam logic [ADDR_W-1:0] IN_LAST  = ADDR_W'(N_IN - 1);
	localparam logic [ADDR_W-1:0] HID_LAST = ADDR_W'(N_HID - 1);
	localparam logic [ADDR_W-1:0] OUT_LAST = ADDR_W'(N_OUT - 1);

	function automatic logic [DATA_W-1:0] fx_mul(input logic [DATA_W-1:0] a,
			input logic [DATA_W-1:0] b);
		logic signed [2*DATA_W-1:0] prod;
		prod = $signed(a) * $signed(b);
		return prod[FRAC_W +: DATA_W]; // Floor, wraps on overflow
	endfunction

	function automatic logic [DATA_W-1:0] fx_leaky_deriv(input logic [DATA_W-1:0] value,
			input logic sign);
		logic signed [DATA_W-1:0] sval;
		sval = value;
		if (sign)
			return sval >>> LEAKY_SHIFT;
		return value;
	endfunction

	function automatic logic [DATA_W-1:0] fx_lr(input logic [DATA_W-1:0] value);
		logic signed [DATA_W-1:0] sval;
		sval = value;
		return sval >>> LR_SHIFT;
	endfunction
endpackage
